/* Makefile */
SRCS := $(shell grep -v '^+' ex1Stage.f) common/ex1_defines.svh sim/ex1Vectors.svh

obj_dir/Vex1StageTb: $(SRCS) ex1Stage.f
	verilator --binary --timing -f ex1Stage.f --top-module ex1StageTb -o Vex1StageTb

run: obj_dir/Vex1StageTb
	./obj_dir/Vex1StageTb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* common/ex1Pkg.sv */
// EX1 stage types
// opcode, IXT sub-op, memory op mode and datapath select encodings

package ex1Pkg;

	// condition code, opUCmd[7:6]
	typedef enum logic [1:0] {
		CC_AL = 2'b00,	// always
		CC_NV = 2'b01,	// never
		CC_CT = 2'b10,	// if SR.T
		CC_CF = 2'b11	// if !SR.T
	} ccT;

	// opcode, opUCmd[5:0]
	typedef enum logic [5:0] {
		UCMD_NOP    = 6'h00,
		UCMD_INVOP  = 6'h01,
		UCMD_LEA_MR = 6'h02,
		UCMD_MOV_RM = 6'h03,	// store
		UCMD_MOV_MR = 6'h04,	// load
		UCMD_PUSHX  = 6'h05,
		UCMD_POPX   = 6'h06,
		UCMD_ADDSP  = 6'h07,
		UCMD_MOV_IR = 6'h08,	// LDI family, sub-op in opUIxt[3:0]
		UCMD_BRA    = 6'h09,
		UCMD_BRA_NB = 6'h0A,	// branch not taken
		UCMD_BSR    = 6'h0B,
		UCMD_JMP    = 6'h0C,
		UCMD_JSR    = 6'h0D,
		UCMD_SHAD3  = 6'h0E,
		UCMD_SHLD3  = 6'h0F,
		UCMD_SHADQ3 = 6'h10,
		UCMD_SHLDQ3 = 6'h11,
		UCMD_OP_IXT = 6'h12	// sub-op in opUIxt[5:0]
	} ucmdT;

	// OP_IXT sub-ops
	typedef enum logic [5:0] {
		IXT_NOP   = 6'h00,
		IXT_BREAK = 6'h01,
		IXT_CLRT  = 6'h02,
		IXT_SETT  = 6'h03,
		IXT_CLRS  = 6'h04,
		IXT_SETS  = 6'h05,
		IXT_NOTT  = 6'h06,
		IXT_NOTS  = 6'h07,
		IXT_MOVT  = 6'h08,
		IXT_MOVNT = 6'h09,
		IXT_TRAPA = 6'h0A,
		IXT_RTE   = 6'h0B
	} ixtT;

	// memory op mode: {st, ld, unsigned, size log2}
	typedef enum logic [4:0] {
		OPM_READY = 5'b00000,	// idle
		OPM_RD_Q  = 5'b01011,	// 64-bit load
		OPM_WR_Q  = 5'b10011	// 64-bit store
	} memOpmT;

	// GPR writeback value source
	typedef enum logic [3:0] {
		RNSEL_NONE, RNSEL_LEA, RNSEL_IMM, RNSEL_SHL8, RNSEL_SHL16, RNSEL_SHL32,
		RNSEL_RT, RNSEL_SHIFT32S, RNSEL_SHIFT32U, RNSEL_SHIFT64, RNSEL_SRT, RNSEL_NSRT
	} rnSelT;

	// CR writeback value source
	typedef enum logic [1:0] {
		CNSEL_NONE, CNSEL_PCSEQ, CNSEL_BRATARGET, CNSEL_RSJUMP
	} cnSelT;

	// next SP source
	typedef enum logic [1:0] {
		SPSEL_KEEP, SPSEL_SUB8, SPSEL_ADD8, SPSEL_ADDIMM
	} spSelT;

endpackage

/* common/ex1_defines.svh */
// EX1 stage shared constants
// datapath widths, register IDs, stack step and trap codes
// used by the EX1 RTL and the testbench

`ifndef EX1_DEFINES_SVH
`define EX1_DEFINES_SVH

// datapath widths
`define EX1_XLEN		64		// GPR / CR width
`define EX1_VADDR		48		// virtual address width
`define EX1_GRID_W		6		// GPR ID width
`define EX1_CRID_W		5		// CR ID width

// register IDs
`define EX1_GR_ZZR		6'h3F	// no GPR write this cycle
`define EX1_CR_ZZR		5'h1F	// no CR write this cycle
`define EX1_CR_PC		5'h00	// PC as a control register

// push/pop step in bytes, one quadword
`define EX1_SP_STEP		8

// trap codes raised toward the exception unit
`define EX1_TRAP_RTE		16'hFF00
`define EX1_TRAP_TRAPA_BASE	12'hC08	// low nibble from Rm ID

`endif

/* ex1Stage.f */
+incdir+common
+incdir+sim
common/ex1Pkg.sv
hw/ex1/addrGenUnit.sv
hw/ex1/shiftUnit.sv
hw/ex1/stackPointerUnit.sv
hw/ex1/resultMux.sv
hw/ex1/ex1Control.sv
hw/ex1/ex1Stage.sv
sim/ex1StageTb.sv

/* hw/ex1/addrGenUnit.sv */
// EX1 address generation
// 48-bit base plus index scaled by the access size,
// and the PC-relative branch target built from it

`timescale 1ns/1ns
`include "ex1_defines.svh"

module addrGenUnit (
	input  logic [`EX1_VADDR-1:0]  regValRs,	// base
	input  logic [`EX1_VADDR-1:0]  regValRt,	// index
	input  logic [7:0]             opUIxt,		// scale in 5:4
	input  logic [`EX1_VADDR-1:0]  regValPc,
	output logic [`EX1_VADDR-1:0]  aguAddr,
	output logic [`EX1_XLEN-1:0]   braTarget
);

	logic [`EX1_VADDR-1:0] scaledIdx;

	// scale 1, 2, 4 or 8 bytes
	assign scaledIdx = regValRt << opUIxt[5:4];
	assign aguAddr   = regValRs + scaledIdx;

	// branches stay inside the current 4GB region
	assign braTarget = {
		{(`EX1_XLEN-`EX1_VADDR){1'b0}},
		regValPc[`EX1_VADDR-1:32],
		aguAddr[31:0]
	};

endmodule

/* hw/ex1/ex1Control.sv */
// EX1 control
// condition gating and opcode decode for the EX1 stage
// drives writeback IDs, datapath selects, memory op mode,
// SR/LR updates, trap codes and the hold toward earlier stages

`timescale 1ns/1ns
`include "ex1_defines.svh"

module ex1Control (
	input  logic                    clock,		// pipeline interface, logic is combinational
	input  logic                    rst,
	input  logic [7:0]              opUCmd,
	input  logic [7:0]              opUIxt,
	input  logic [`EX1_GRID_W-1:0]  regIdRm,
	input  logic                    opBraFlush,
	input  logic                    opPreBra,	// branch already taken by the front end
	input  logic [`EX1_VADDR-1:0]   regValPc,
	input  logic [`EX1_VADDR-1:0]   regInLr,
	input  logic [`EX1_XLEN-1:0]    regInSr,
	output logic [`EX1_GRID_W-1:0]  regIdRn1,
	output logic [`EX1_CRID_W-1:0]  regIdCn1,
	output logic [`EX1_GRID_W-1:0]  heldIdRn1,
	output logic [`EX1_VADDR-1:0]   regOutLr,
	output logic [`EX1_XLEN-1:0]    regOutSr,
	output ex1Pkg::rnSelT           rnSel,
	output ex1Pkg::cnSelT           cnSel,
	output ex1Pkg::spSelT           spSel,
	output logic                    shiftArith,
	output logic                    memFromSp,
	output ex1Pkg::memOpmT          memOpm,
	output logic                    exHold,
	output logic [15:0]             exTrapExc
);

	ex1Pkg::ccT    cc;
	ex1Pkg::ucmdT  rawCmd;
	ex1Pkg::ucmdT  cancelCmd;	// what a disabled op turns into
	ex1Pkg::ucmdT  cmd;
	logic          opEnable;

	assign cc     = ex1Pkg::ccT'(opUCmd[7:6]);
	assign rawCmd = ex1Pkg::ucmdT'(opUCmd[5:0]);

	// condition check against SR.T, a flush kills everything
	always_comb begin
		opEnable = 1'b0;
		if (!opBraFlush) begin
			case (cc)
				ex1Pkg::CC_AL: opEnable = 1'b1;
				ex1Pkg::CC_NV: opEnable = 1'b0;
				ex1Pkg::CC_CT: opEnable = regInSr[0];
				ex1Pkg::CC_CF: opEnable = !regInSr[0];
				default:       opEnable = 1'b0;
			endcase
		end
	end

	// cancelled BRA still has to undo a predicted branch
	assign cancelCmd = (!opBraFlush && rawCmd == ex1Pkg::UCMD_BRA) ?
		ex1Pkg::UCMD_BRA_NB : ex1Pkg::UCMD_NOP;
	assign cmd = opEnable ? rawCmd : cancelCmd;

	always_comb begin
		// inactive defaults
		regIdRn1   = `EX1_GR_ZZR;
		regIdCn1   = `EX1_CR_ZZR;
		heldIdRn1  = `EX1_GR_ZZR;
		regOutLr   = regInLr;
		regOutSr   = regInSr;
		rnSel      = ex1Pkg::RNSEL_NONE;
		cnSel      = ex1Pkg::CNSEL_NONE;
		spSel      = ex1Pkg::SPSEL_KEEP;
		shiftArith = 1'b0;
		memFromSp  = 1'b0;
		memOpm     = ex1Pkg::OPM_READY;
		exHold     = 1'b0;
		exTrapExc  = 16'h0000;

		case (cmd)
			ex1Pkg::UCMD_NOP: begin
			end
			ex1Pkg::UCMD_INVOP: exHold = !rst;
			ex1Pkg::UCMD_LEA_MR: begin
				regIdRn1 = regIdRm;
				rnSel    = ex1Pkg::RNSEL_LEA;
			end
			ex1Pkg::UCMD_MOV_RM: begin	// store, size and sign from ext byte
				memOpm = ex1Pkg::memOpmT'({2'b10, opUIxt[2], opUIxt[5:4]});
			end
			ex1Pkg::UCMD_MOV_MR: begin	// load data shows up in EX2
				memOpm    = ex1Pkg::memOpmT'({2'b01, opUIxt[2], opUIxt[5:4]});
				heldIdRn1 = regIdRm;
			end
			ex1Pkg::UCMD_PUSHX: begin
				spSel     = ex1Pkg::SPSEL_SUB8;
				memFromSp = 1'b1;
				memOpm    = ex1Pkg::OPM_WR_Q;
			end
			ex1Pkg::UCMD_POPX: begin
				spSel     = ex1Pkg::SPSEL_ADD8;
				memFromSp = 1'b1;
				memOpm    = ex1Pkg::OPM_RD_Q;
				heldIdRn1 = regIdRm;	// popped value lands later
			end
			ex1Pkg::UCMD_ADDSP: spSel = ex1Pkg::SPSEL_ADDIMM;
			ex1Pkg::UCMD_MOV_IR: begin
				regIdRn1 = regIdRm;
				case (opUIxt[3:0])
					4'h0:    rnSel = ex1Pkg::RNSEL_IMM;		// LDI
					4'h1:    rnSel = ex1Pkg::RNSEL_SHL8;
					4'h2:    rnSel = ex1Pkg::RNSEL_SHL16;
					4'h3:    rnSel = ex1Pkg::RNSEL_SHL32;
					default: rnSel = ex1Pkg::RNSEL_RT;		// JLDIX and spares
				endcase
			end
			ex1Pkg::UCMD_BRA_NB: begin
				// predicted taken but not, go back to sequential PC
				if (opPreBra) begin
					regIdCn1 = `EX1_CR_PC;
					cnSel    = ex1Pkg::CNSEL_PCSEQ;
				end
			end
			ex1Pkg::UCMD_BRA, ex1Pkg::UCMD_BSR: begin
				if (cmd == ex1Pkg::UCMD_BSR)
					regOutLr = regValPc;
				if (!opPreBra) begin	// not yet redirected by the front end
					regIdCn1 = `EX1_CR_PC;
					cnSel    = ex1Pkg::CNSEL_BRATARGET;
				end
			end
			ex1Pkg::UCMD_JMP, ex1Pkg::UCMD_JSR: begin
				if (cmd == ex1Pkg::UCMD_JSR)
					regOutLr = regValPc;
				regIdCn1 = `EX1_CR_PC;
				cnSel    = ex1Pkg::CNSEL_RSJUMP;
			end
			ex1Pkg::UCMD_SHAD3, ex1Pkg::UCMD_SHLD3: begin
				regIdRn1   = regIdRm;
				shiftArith = (cmd == ex1Pkg::UCMD_SHAD3);
				rnSel      = shiftArith ? ex1Pkg::RNSEL_SHIFT32S : ex1Pkg::RNSEL_SHIFT32U;
			end
			ex1Pkg::UCMD_SHADQ3, ex1Pkg::UCMD_SHLDQ3: begin
				regIdRn1   = regIdRm;
				shiftArith = (cmd == ex1Pkg::UCMD_SHADQ3);
				rnSel      = ex1Pkg::RNSEL_SHIFT64;
			end
			ex1Pkg::UCMD_OP_IXT: begin
				case (ex1Pkg::ixtT'(opUIxt[5:0]))
					ex1Pkg::IXT_NOP: begin
					end
					ex1Pkg::IXT_BREAK: exHold = !rst;
					ex1Pkg::IXT_CLRT:  regOutSr[0] = 1'b0;
					ex1Pkg::IXT_SETT:  regOutSr[0] = 1'b1;
					ex1Pkg::IXT_CLRS:  regOutSr[1] = 1'b0;
					ex1Pkg::IXT_SETS:  regOutSr[1] = 1'b1;
					ex1Pkg::IXT_NOTT:  regOutSr[0] = !regInSr[0];
					ex1Pkg::IXT_NOTS:  regOutSr[1] = !regInSr[1];
					ex1Pkg::IXT_MOVT: begin
						regIdRn1 = regIdRm;
						rnSel    = ex1Pkg::RNSEL_SRT;
					end
					ex1Pkg::IXT_MOVNT: begin
						regIdRn1 = regIdRm;
						rnSel    = ex1Pkg::RNSEL_NSRT;
					end
					ex1Pkg::IXT_TRAPA: exTrapExc = {`EX1_TRAP_TRAPA_BASE, regIdRm[3:0]};
					ex1Pkg::IXT_RTE:   exTrapExc = `EX1_TRAP_RTE;
					default:           exHold = !rst;	// unknown sub-op
				endcase
			end
			default: exHold = !rst;	// unknown opcode, stall until replaced
		endcase
	end

endmodule

/* hw/ex1/ex1Stage.sv */
// EX1 stage top
// first execute stage of the 64-bit in-order pipeline
// control decodes the micro-op, four datapath units build the results
// purely combinational, only starts loads and stores

`timescale 1ns/1ns
`include "ex1_defines.svh"

module ex1Stage (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [7:0]              opUCmd,		// cc in 7:6, opcode in 5:0
	input  logic [7:0]              opUIxt,
	input  logic [`EX1_GRID_W-1:0]  regIdRm,
	input  logic [`EX1_XLEN-1:0]    regValRs,	// base / source A
	input  logic [`EX1_XLEN-1:0]    regValRt,	// index / source B
	input  logic [`EX1_XLEN-1:0]    regValRm,	// store value
	input  logic [`EX1_VADDR-1:0]   regValPc,
	input  logic [32:0]             regValImm,
	input  logic                    opBraFlush,
	input  logic                    opPreBra,
	input  logic [`EX1_XLEN-1:0]    regInSp,
	input  logic [`EX1_VADDR-1:0]   regInLr,
	input  logic [`EX1_XLEN-1:0]    regInSr,
	output logic [`EX1_GRID_W-1:0]  regIdRn1,
	output logic [`EX1_XLEN-1:0]    regValRn1,
	output logic [`EX1_CRID_W-1:0]  regIdCn1,
	output logic [`EX1_XLEN-1:0]    regValCn1,
	output logic [`EX1_GRID_W-1:0]  heldIdRn1,
	output logic [`EX1_XLEN-1:0]    regOutSp,
	output logic [`EX1_VADDR-1:0]   regOutLr,
	output logic [`EX1_XLEN-1:0]    regOutSr,
	output logic [`EX1_VADDR-1:0]   memAddr,
	output ex1Pkg::memOpmT          memOpm,
	output logic [`EX1_XLEN-1:0]    memDataOut,
	output logic                    exHold,
	output logic [15:0]             exTrapExc
);

	ex1Pkg::rnSelT            rnSel;
	ex1Pkg::cnSelT            cnSel;
	ex1Pkg::spSelT            spSel;
	logic                     shiftArith;
	logic                     memFromSp;	// push/pop address from SP
	logic [`EX1_VADDR-1:0]    aguAddr;
	logic [`EX1_XLEN-1:0]     braTarget;
	logic [31:0]              shift32;
	logic [`EX1_XLEN-1:0]     shift64;

	ex1Control u_ex1Control (
		.clock, .rst, .opUCmd, .opUIxt, .regIdRm, .opBraFlush, .opPreBra,
		.regValPc, .regInLr, .regInSr,
		.regIdRn1, .regIdCn1, .heldIdRn1, .regOutLr, .regOutSr,
		.rnSel, .cnSel, .spSel, .shiftArith, .memFromSp, .memOpm,
		.exHold, .exTrapExc
	);

	addrGenUnit u_addrGenUnit (
		.regValRs  (regValRs[`EX1_VADDR-1:0]),
		.regValRt  (regValRt[`EX1_VADDR-1:0]),
		.opUIxt, .regValPc, .aguAddr, .braTarget
	);

	shiftUnit u_shiftUnit (
		.regValRs, .regValRt, .shiftArith, .shift32, .shift64
	);

	stackPointerUnit u_stackPointerUnit (
		.regInSp, .regValImm, .spSel, .memFromSp, .aguAddr, .regOutSp, .memAddr
	);

	resultMux u_resultMux (
		.rnSel, .cnSel, .spSel, .aguAddr, .braTarget, .shift32, .shift64,
		.regValRs, .regValRt, .regValRm, .regValImm, .regValPc, .regInSr,
		.regValRn1, .regValCn1, .memDataOut
	);

endmodule

/* hw/ex1/resultMux.sv */
// EX1 result mux
// picks the GPR and CR writeback values and the store data
// from the datapath units and the register operands

`timescale 1ns/1ns
`include "ex1_defines.svh"

module resultMux (
	input  ex1Pkg::rnSelT          rnSel,
	input  ex1Pkg::cnSelT          cnSel,
	input  ex1Pkg::spSelT          spSel,		// push selects Rs as store data
	input  logic [`EX1_VADDR-1:0]  aguAddr,
	input  logic [`EX1_XLEN-1:0]   braTarget,
	input  logic [31:0]            shift32,
	input  logic [`EX1_XLEN-1:0]   shift64,
	input  logic [`EX1_XLEN-1:0]   regValRs,
	input  logic [`EX1_XLEN-1:0]   regValRt,
	input  logic [`EX1_XLEN-1:0]   regValRm,
	input  logic [32:0]            regValImm,
	input  logic [`EX1_VADDR-1:0]  regValPc,
	input  logic [`EX1_XLEN-1:0]   regInSr,
	output logic [`EX1_XLEN-1:0]   regValRn1,
	output logic [`EX1_XLEN-1:0]   regValCn1,
	output logic [`EX1_XLEN-1:0]   memDataOut
);

	localparam int PadW = `EX1_XLEN - `EX1_VADDR;	// zero pad above an address

	logic srT;
	assign srT = regInSr[0];

	// GPR value
	always_comb begin
		case (rnSel)
			ex1Pkg::RNSEL_LEA:      regValRn1 = {{PadW{1'b0}}, aguAddr};
			ex1Pkg::RNSEL_IMM:      regValRn1 = {{31{regValImm[32]}}, regValImm};
			ex1Pkg::RNSEL_SHL8:     regValRn1 = {regValRs[55:0], regValImm[7:0]};
			ex1Pkg::RNSEL_SHL16:    regValRn1 = {regValRs[47:0], regValImm[15:0]};
			ex1Pkg::RNSEL_SHL32:    regValRn1 = {regValRs[31:0], regValImm[31:0]};
			ex1Pkg::RNSEL_RT:       regValRn1 = regValRt;	// JLDIX
			ex1Pkg::RNSEL_SHIFT32S: regValRn1 = {{32{shift32[31]}}, shift32};
			ex1Pkg::RNSEL_SHIFT32U: regValRn1 = {32'h0, shift32};
			ex1Pkg::RNSEL_SHIFT64:  regValRn1 = shift64;
			ex1Pkg::RNSEL_SRT:      regValRn1 = {63'h0, srT};
			ex1Pkg::RNSEL_NSRT:     regValRn1 = {63'h0, !srT};
			default:                regValRn1 = '0;
		endcase
	end

	// CR value, only PC writes reach here
	always_comb begin
		case (cnSel)
			ex1Pkg::CNSEL_PCSEQ:     regValCn1 = {{PadW{1'b0}}, regValPc};
			ex1Pkg::CNSEL_BRATARGET: regValCn1 = braTarget;
			ex1Pkg::CNSEL_RSJUMP:    regValCn1 = {{PadW{1'b0}}, regValRs[`EX1_VADDR-1:0]};
			default:                 regValCn1 = '0;
		endcase
	end

	assign memDataOut = (spSel == ex1Pkg::SPSEL_SUB8) ? regValRs : regValRm;

endmodule

/* hw/ex1/shiftUnit.sv */
// EX1 shifter
// shift by a signed 8-bit count, left if positive, right if negative
// 32- and 64-bit results, arithmetic or logical right shift

`timescale 1ns/1ns
`include "ex1_defines.svh"

module shiftUnit (
	input  logic [`EX1_XLEN-1:0]  regValRs,
	input  logic [`EX1_XLEN-1:0]  regValRt,	// count in 7:0
	input  logic                  shiftArith,
	output logic [31:0]           shift32,
	output logic [`EX1_XLEN-1:0]  shift64
);

	logic [`EX1_XLEN-1:0] ext32;	// 32-bit operand widened
	logic [`EX1_XLEN-1:0] res32;

	// shared by both widths, width sets the out-of-range limit
	function automatic logic [`EX1_XLEN-1:0] shiftBy(
		input logic [`EX1_XLEN-1:0] val,
		input logic [7:0]           cnt,
		input logic                 arith,
		input logic [6:0]           width
	);
		logic [7:0] mag;
		logic       fill;
		mag  = cnt[7] ? (~cnt + 8'd1) : cnt;	// -128 gives 128
		fill = arith & val[`EX1_XLEN-1];
		if (mag >= {1'b0, width})
			shiftBy = cnt[7] ? {`EX1_XLEN{fill}} : '0;
		else if (!cnt[7])
			shiftBy = val << mag;
		else if (arith)
			shiftBy = $signed(val) >>> mag;
		else
			shiftBy = val >> mag;
	endfunction

	// upper half carries the sign so a right shift pulls it in
	assign ext32 = {{32{shiftArith & regValRs[31]}}, regValRs[31:0]};
	assign res32 = shiftBy(ext32, regValRt[7:0], shiftArith, 7'd32);

	assign shift32 = res32[31:0];
	assign shift64 = shiftBy(regValRs, regValRt[7:0], shiftArith, 7'd64);

endmodule

/* hw/ex1/stackPointerUnit.sv */
// EX1 stack pointer unit
// next SP for push, pop and ADDSP, and the memory address mux
// SP arithmetic stays within the low 28 bits

`timescale 1ns/1ns
`include "ex1_defines.svh"

module stackPointerUnit (
	input  logic [`EX1_XLEN-1:0]   regInSp,
	input  logic [32:0]            regValImm,	// ADDSP offset in 15:3
	input  ex1Pkg::spSelT          spSel,
	input  logic                   memFromSp,
	input  logic [`EX1_VADDR-1:0]  aguAddr,
	output logic [`EX1_XLEN-1:0]   regOutSp,
	output logic [`EX1_VADDR-1:0]  memAddr
);

	logic [`EX1_XLEN-1:0]  spSub;
	logic [`EX1_XLEN-1:0]  spAdd;
	logic [`EX1_XLEN-1:0]  spAddImm;
	logic [`EX1_XLEN-1:0]  spNext;
	logic [`EX1_VADDR-1:0] spMemAddr;

	// one quadword step, low 3 bits untouched
	assign spSub = {regInSp[63:28], regInSp[27:0] - 28'(`EX1_SP_STEP)};
	assign spAdd = {regInSp[63:28], regInSp[27:0] + 28'(`EX1_SP_STEP)};
	assign spAddImm = {regInSp[63:28],
		regInSp[27:0] + {{12{regValImm[15]}}, regValImm[15:3], 3'b000}};

	always_comb begin
		case (spSel)
			ex1Pkg::SPSEL_SUB8:   spNext = spSub;
			ex1Pkg::SPSEL_ADD8:   spNext = spAdd;
			ex1Pkg::SPSEL_ADDIMM: spNext = spAddImm;
			default:              spNext = regInSp;
		endcase
	end
	assign regOutSp = spNext;

	// push writes below SP, pop reads at SP
	assign spMemAddr = (spSel == ex1Pkg::SPSEL_SUB8) ? spSub[`EX1_VADDR-1:0] :
		regInSp[`EX1_VADDR-1:0];
	assign memAddr = memFromSp ? spMemAddr : aguAddr;

endmodule

/* sim/ex1Vectors.svh */
// EX1 stimulus and expected-value table
// every row starts idle, then sets the inputs and outputs it exercises
// expected values worked out by hand from the stage rules

	task automatic fillTable();
		logic [63:0] rA;
		logic [63:0] rB;
		logic [63:0] rC;
		rA = {$urandom, $urandom};
		rB = {$urandom, $urandom};
		rC = {$urandom, $urandom};

		// gating on SR.T, NV and flush
		beginRow("ldi_ct_tset", ex1Pkg::CC_CT, ex1Pkg::UCMD_MOV_IR, 8'h00);
		setSr(64'h1);
		cur.regValImm = 33'h1_8000_0001;	// bit 32 set, sign-extends
		expectRn(6'h04, 64'hFFFF_FFFF_8000_0001);
		addRow();
		beginRow("ldi_ct_tclr", ex1Pkg::CC_CT, ex1Pkg::UCMD_MOV_IR, 8'h00);
		cur.regValImm = 33'h1_8000_0001;
		addRow();
		beginRow("ldi_cf_tclr", ex1Pkg::CC_CF, ex1Pkg::UCMD_MOV_IR, 8'h00);
		cur.regValImm = 33'h0_1234_5678;
		expectRn(6'h04, 64'h0000_0000_1234_5678);
		addRow();
		beginRow("ldi_nv", ex1Pkg::CC_NV, ex1Pkg::UCMD_MOV_IR, 8'h00);
		cur.regValImm = 33'h0_1234_5678;
		addRow();
		beginRow("bra_flush", ex1Pkg::CC_AL, ex1Pkg::UCMD_BRA, 8'h00);
		cur.opBraFlush = 1'b1;
		cur.opPreBra   = 1'b1;	// killed, so no PC repair either
		addRow();
		beginRow("bra_cf_prebra", ex1Pkg::CC_CF, ex1Pkg::UCMD_BRA, 8'h00);
		setSr(64'h1);
		cur.opPreBra = 1'b1;
		expectPc({16'h0, pcIdle});	// back to sequential PC
		addRow();

		// LDI family
		beginRow("ldish8", ex1Pkg::CC_AL, ex1Pkg::UCMD_MOV_IR, 8'h01);
		cur.regValRs  = rA;
		cur.regValImm = 33'h0_0000_00A5;
		expectRn(6'h04, {rA[55:0], 8'hA5});
		addRow();
		beginRow("ldish16", ex1Pkg::CC_AL, ex1Pkg::UCMD_MOV_IR, 8'h02);
		cur.regValRs  = rA;
		cur.regValImm = 33'h0_0000_BEEF;
		expectRn(6'h04, {rA[47:0], 16'hBEEF});
		addRow();
		beginRow("ldish32", ex1Pkg::CC_AL, ex1Pkg::UCMD_MOV_IR, 8'h03);
		cur.regValRs  = rA;
		cur.regValImm = 33'h0_CAFE_F00D;
		expectRn(6'h04, {rA[31:0], 32'hCAFE_F00D});
		addRow();
		beginRow("jldix", ex1Pkg::CC_AL, ex1Pkg::UCMD_MOV_IR, 8'h04);
		cur.regValRt = rB;
		expectRn(6'h04, rB);
		addRow();

		// LEA, load, store, stack
		beginRow("lea_scale4", ex1Pkg::CC_AL, ex1Pkg::UCMD_LEA_MR, 8'h20);
		cur.regValRs = rA;
		cur.regValRt = 64'h3;
		expectRn(6'h04, {16'h0, rA[47:0] + 48'hC});
		addRow();
		beginRow("load_q_unsigned", ex1Pkg::CC_AL, ex1Pkg::UCMD_MOV_MR, 8'h34);
		cur.regIdRm  = 6'h09;
		cur.regValRs = rA;
		cur.regValRt = 64'h10;
		cur.expHeld  = 6'h09;	// value arrives later
		expectMem(5'b01111, rA[47:0] + 48'h80, 64'h0);
		addRow();
		beginRow("store_w", ex1Pkg::CC_AL, ex1Pkg::UCMD_MOV_RM, 8'h10);
		cur.regValRs = 64'h0000_5555_0000_1000;
		cur.regValRt = 64'h8;
		cur.regValRm = rC;
		expectMem(5'b10001, 48'h5555_0000_1010, rC);
		addRow();
		beginRow("pushx", ex1Pkg::CC_AL, ex1Pkg::UCMD_PUSHX, 8'h00);
		cur.regValRs = rB;
		cur.expSp    = 64'hA5A5_0000_0010_0038;
		expectMem(ex1Pkg::OPM_WR_Q, 48'h0000_0010_0038, rB);
		addRow();
		beginRow("popx", ex1Pkg::CC_AL, ex1Pkg::UCMD_POPX, 8'h00);
		cur.regIdRm  = 6'h07;
		cur.regValRm = rC;
		cur.expHeld  = 6'h07;
		cur.expSp    = 64'hA5A5_0000_0010_0048;
		expectMem(ex1Pkg::OPM_RD_Q, 48'h0000_0010_0040, rC);	// old SP
		addRow();
		beginRow("addsp_neg", ex1Pkg::CC_AL, ex1Pkg::UCMD_ADDSP, 8'h00);
		cur.regValImm = 33'h0_0000_FFF0;	// -2 quadwords
		cur.expSp     = 64'hA5A5_0000_0010_0030;
		addRow();
		beginRow("addsp_pos", ex1Pkg::CC_AL, ex1Pkg::UCMD_ADDSP, 8'h00);
		cur.regValImm = 33'h0_0000_0100;
		cur.expSp     = 64'hA5A5_0000_0010_0140;
		addRow();

		// shifts, count in Rt[7:0]
		beginRow("shad3_left", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHAD3, 8'h00);
		cur.regValRs = 64'h1234_5678_8000_0011;
		cur.regValRt = 64'h4;
		expectRn(6'h04, 64'h0000_0000_0000_0110);
		addRow();
		beginRow("shad3_right", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHAD3, 8'h00);
		cur.regValRs = 64'h1234_5678_8000_0011;
		cur.regValRt = 64'hFC;	// -4
		expectRn(6'h04, 64'hFFFF_FFFF_F800_0001);
		addRow();
		beginRow("shld3_right", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHLD3, 8'h00);
		cur.regValRs = 64'h1234_5678_8000_0011;
		cur.regValRt = 64'hFC;
		expectRn(6'h04, 64'h0000_0000_0800_0001);
		addRow();
		beginRow("shad3_range", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHAD3, 8'h00);
		cur.regValRs = 64'h1234_5678_8000_0011;
		cur.regValRt = 64'hD8;	// -40, past the width
		expectRn(6'h04, 64'hFFFF_FFFF_FFFF_FFFF);
		addRow();
		beginRow("shadq3_right", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHADQ3, 8'h00);
		cur.regValRs = 64'h8000_0000_0000_0100;
		cur.regValRt = 64'hF8;
		expectRn(6'h04, 64'hFF80_0000_0000_0001);
		addRow();
		beginRow("shldq3_left", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHLDQ3, 8'h00);
		cur.regValRs = 64'hFF;
		cur.regValRt = 64'h3C;
		expectRn(6'h04, 64'hF000_0000_0000_0000);
		addRow();
		beginRow("shldq3_range", ex1Pkg::CC_AL, ex1Pkg::UCMD_SHLDQ3, 8'h00);
		cur.regValRs = rA;
		cur.regValRt = 64'h80;	// -128
		expectRn(6'h04, 64'h0);
		addRow();

		// branches, target keeps PC[47:32]
		beginRow("bra", ex1Pkg::CC_AL, ex1Pkg::UCMD_BRA, 8'h00);
		cur.regValRs = 64'h0000_7777_1234_5670;
		cur.regValRt = 64'h10;
		expectPc(64'h0000_0012_1234_5680);
		addRow();
		beginRow("bsr", ex1Pkg::CC_AL, ex1Pkg::UCMD_BSR, 8'h00);
		cur.regValRs = 64'h0000_7777_1234_5670;
		cur.regValRt = 64'h10;
		cur.expLr    = pcIdle;
		expectPc(64'h0000_0012_1234_5680);
		addRow();
		beginRow("jmp", ex1Pkg::CC_AL, ex1Pkg::UCMD_JMP, 8'h00);
		cur.regValRs = rA;
		expectPc({16'h0, rA[47:0]});
		addRow();
		beginRow("jsr", ex1Pkg::CC_AL, ex1Pkg::UCMD_JSR, 8'h00);
		cur.regValRs = rB;
		cur.expLr    = pcIdle;
		expectPc({16'h0, rB[47:0]});
		addRow();

		// IXT group
		beginRow("sett", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h03);
		cur.expSr = 64'h1;
		addRow();
		beginRow("clrs", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h04);
		setSr(64'h3);
		cur.expSr = 64'h1;
		addRow();
		beginRow("nott", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h06);
		setSr(64'h1);
		cur.expSr = 64'h0;
		addRow();
		beginRow("nots", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h07);
		setSr(64'h1);
		cur.expSr = 64'h3;
		addRow();
		beginRow("movt", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h08);
		setSr(64'h1);
		expectRn(6'h04, 64'h1);
		addRow();
		beginRow("movnt", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h09);
		expectRn(6'h04, 64'h1);	// T clear
		addRow();
		beginRow("trapa", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h0A);
		cur.regIdRm = 6'h2B;	// low nibble B
		cur.expTrap = 16'hC08B;
		addRow();
		beginRow("rte", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h0B);
		cur.expTrap = 16'hFF00;
		addRow();
		beginRow("break", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h01);
		cur.expHold = 1'b1;
		addRow();
		beginRow("ixt_unknown", ex1Pkg::CC_AL, ex1Pkg::UCMD_OP_IXT, 8'h20);
		cur.expHold = 1'b1;
		addRow();
		beginRow("op_unknown", ex1Pkg::CC_AL, 6'h3F, 8'h00);
		cur.expHold = 1'b1;
		addRow();
		beginRow("invop", ex1Pkg::CC_AL, ex1Pkg::UCMD_INVOP, 8'h00);
		cur.expHold = 1'b1;
		addRow();
		beginRow("invop_in_rst", ex1Pkg::CC_AL, ex1Pkg::UCMD_INVOP, 8'h00);
		cur.rst = 1'b1;	// hold stays low in reset
		addRow();
	endtask

/* sim/ex1StageTb.sv */
// EX1 stage testbench
// applies the vector table one row per cycle and checks every output
// inputs change 1 ns after the rising edge, outputs sampled 1 ns before the next

`timescale 1ns/1ns
`include "ex1_defines.svh"

module ex1StageTb;

	// one table row, stimulus first, then the expected outputs
	typedef struct packed {
		logic        rst;
		logic [7:0]  opUCmd;
		logic [7:0]  opUIxt;
		logic [5:0]  regIdRm;
		logic [63:0] regValRs;
		logic [63:0] regValRt;
		logic [63:0] regValRm;
		logic [47:0] regValPc;
		logic [32:0] regValImm;
		logic        opBraFlush;
		logic        opPreBra;
		logic [63:0] regInSp;
		logic [47:0] regInLr;
		logic [63:0] regInSr;
		logic [5:0]  expIdRn;
		logic [63:0] expValRn;	// only checked with a real GPR ID
		logic [4:0]  expIdCn;
		logic [63:0] expValCn;	// only checked with a real CR ID
		logic [5:0]  expHeld;
		logic [63:0] expSp;
		logic [47:0] expLr;
		logic [63:0] expSr;
		logic [4:0]  expOpm;
		logic [47:0] expAddr;	// address and data only with a request
		logic [63:0] expData;
		logic        expHold;
		logic [15:0] expTrap;
	} vecT;

	localparam logic [47:0] pcIdle = 48'h0012_4000_1000;
	localparam logic [63:0] spIdle = 64'hA5A5_0000_0010_0040;	// upper bits must survive
	localparam logic [47:0] lrIdle = 48'h0012_4000_0ABC;

	logic                  clock;
	logic                  rst;
	logic [7:0]            opUCmd;
	logic [7:0]            opUIxt;
	logic [5:0]            regIdRm;
	logic [63:0]           regValRs;
	logic [63:0]           regValRt;
	logic [63:0]           regValRm;
	logic [47:0]           regValPc;
	logic [32:0]           regValImm;
	logic                  opBraFlush;
	logic                  opPreBra;
	logic [63:0]           regInSp;
	logic [47:0]           regInLr;
	logic [63:0]           regInSr;
	logic [5:0]            regIdRn1;
	logic [63:0]           regValRn1;
	logic [4:0]            regIdCn1;
	logic [63:0]           regValCn1;
	logic [5:0]            heldIdRn1;
	logic [63:0]           regOutSp;
	logic [47:0]           regOutLr;
	logic [63:0]           regOutSr;
	logic [47:0]           memAddr;
	ex1Pkg::memOpmT        memOpm;
	logic [63:0]           memDataOut;
	logic                  exHold;
	logic [15:0]           exTrapExc;

	vecT   vectors[$];
	string names[$];
	vecT   cur;			// row under construction
	int    cycles = 0;
	int    goodRows = 0;
	int    badRows = 0;
	int    rowErrs = 0;

	ex1Stage u_ex1Stage (.*);

	task automatic driveInputs(input vecT v);
		rst        = v.rst;
		opUCmd     = v.opUCmd;
		opUIxt     = v.opUIxt;
		regIdRm    = v.regIdRm;
		regValRs   = v.regValRs;
		regValRt   = v.regValRt;
		regValRm   = v.regValRm;
		regValPc   = v.regValPc;
		regValImm  = v.regValImm;
		opBraFlush = v.opBraFlush;
		opPreBra   = v.opPreBra;
		regInSp    = v.regInSp;
		regInLr    = v.regInLr;
		regInSr    = v.regInSr;
	endtask

	task automatic reportMismatch(input string test, input string field,
		input logic [63:0] exp, input logic [63:0] act);
		$display("Error %s %s: expected %h, actual %h", test, field, exp, act);
		rowErrs++;
	endtask

	// idle inputs, inactive outputs, SP/LR/SR passed through
	task automatic beginRow(input string name, input ex1Pkg::ccT cc, input logic [5:0] op,
		input logic [7:0] ixt);
		cur          = '0;
		cur.opUCmd   = {cc, op};
		cur.opUIxt   = ixt;
		cur.regIdRm  = 6'h04;
		cur.regValPc = pcIdle;
		cur.regInSp  = spIdle;
		cur.regInLr  = lrIdle;
		cur.expIdRn  = `EX1_GR_ZZR;
		cur.expIdCn  = `EX1_CR_ZZR;
		cur.expHeld  = `EX1_GR_ZZR;
		cur.expSp    = spIdle;
		cur.expLr    = lrIdle;
		names.push_back(name);
	endtask

	task automatic setSr(input logic [63:0] sr);
		cur.regInSr = sr;
		cur.expSr   = sr;	// unchanged unless the row says so
	endtask

	task automatic expectRn(input logic [5:0] id, input logic [63:0] val);
		cur.expIdRn  = id;
		cur.expValRn = val;
	endtask

	task automatic expectPc(input logic [63:0] val);
		cur.expIdCn  = `EX1_CR_PC;
		cur.expValCn = val;
	endtask

	task automatic expectMem(input logic [4:0] opm, input logic [47:0] addr,
		input logic [63:0] data);
		cur.expOpm  = opm;
		cur.expAddr = addr;
		cur.expData = data;
	endtask

	task automatic addRow();
		vectors.push_back(cur);
	endtask

	`include "ex1Vectors.svh"

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// limit is the table length plus reset and slack
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > vectors.size() + 20) begin
			$display("Timeout, the vector loop did not finish within %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		vecT v;
		void'($urandom(65167));
		cur      = '0;
		cur.rst  = 1'b1;
		cur.regValPc = pcIdle;
		cur.regInSp  = spIdle;
		cur.regInLr  = lrIdle;
		driveInputs(cur);
		fillTable();
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;
		for (int i = 0; i < vectors.size(); i++) begin
			@(posedge clock);
			#1;
			v = vectors[i];
			driveInputs(v);
			#2;	// 1 ns before the next edge
			rowErrs = 0;
			if (regIdRn1 !== v.expIdRn)
				reportMismatch(names[i], "regIdRn1", 64'(v.expIdRn), 64'(regIdRn1));
			if (v.expIdRn != `EX1_GR_ZZR && regValRn1 !== v.expValRn)
				reportMismatch(names[i], "regValRn1", v.expValRn, regValRn1);
			if (regIdCn1 !== v.expIdCn)
				reportMismatch(names[i], "regIdCn1", 64'(v.expIdCn), 64'(regIdCn1));
			if (v.expIdCn != `EX1_CR_ZZR && regValCn1 !== v.expValCn)
				reportMismatch(names[i], "regValCn1", v.expValCn, regValCn1);
			if (heldIdRn1 !== v.expHeld)
				reportMismatch(names[i], "heldIdRn1", 64'(v.expHeld), 64'(heldIdRn1));
			if (regOutSp !== v.expSp)
				reportMismatch(names[i], "regOutSp", v.expSp, regOutSp);
			if (regOutLr !== v.expLr)
				reportMismatch(names[i], "regOutLr", 64'(v.expLr), 64'(regOutLr));
			if (regOutSr !== v.expSr)
				reportMismatch(names[i], "regOutSr", v.expSr, regOutSr);
			if (memOpm !== v.expOpm)
				reportMismatch(names[i], "memOpm", 64'(v.expOpm), 64'(memOpm));
			if (v.expOpm != 5'b0 && memAddr !== v.expAddr)
				reportMismatch(names[i], "memAddr", 64'(v.expAddr), 64'(memAddr));
			if (v.expOpm != 5'b0 && memDataOut !== v.expData)
				reportMismatch(names[i], "memDataOut", v.expData, memDataOut);
			if (exHold !== v.expHold)
				reportMismatch(names[i], "exHold", 64'(v.expHold), 64'(exHold));
			if (exTrapExc !== v.expTrap)
				reportMismatch(names[i], "exTrapExc", 64'(v.expTrap), 64'(exTrapExc));
			if (rowErrs == 0) begin
				goodRows++;
				$display("%s: ok", names[i]);
			end else begin
				badRows++;
				$display("%s: %0d mismatches", names[i], rowErrs);
			end
		end
		$display("rows %0d, ok %0d, with errors %0d", vectors.size(), goodRows, badRows);
		if (badRows == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
